// File: sources.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/ctrl_if.sv
verilog/instr_fifo.sv
verilog/alu_decoder.sv
verilog/mem_decoder.sv
verilog/flow_decoder.sv
verilog/decode_pipe.sv
verilog/decode_stage_top.sv
tb/decode_chk.sv
tb/decode_tb.sv

// File: tb/decode_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_defs.svh"

module decode_tb import ctrl_pkg::*; ();

    localparam int CLK_NS   = 40;
    localparam int N_KINDS  = 48;
    localparam int N_RANDOM = 64;
    localparam int N_WORDS  = N_KINDS + 1 + N_RANDOM;   // Plus the NOP

    // {opcode, funct} in octal, REGIMM keeps rt bit 16 in funct bit 0
    localparam logic [11:0] KINDS [N_KINDS] = '{
        12'o0040, 12'o0041, 12'o0042, 12'o0043, 12'o0044, 12'o0045, 12'o0046, 12'o0047,
        12'o0052, 12'o0053, 12'o0000, 12'o0004, 12'o0003, 12'o0007, 12'o0002, 12'o0006,
        12'o0010, 12'o3440, 12'o3441,
        12'o1000, 12'o1100, 12'o1200, 12'o1300, 12'o1400, 12'o1500, 12'o1600, 12'o1700,
        12'o4000, 12'o4400, 12'o4100, 12'o4500, 12'o4300, 12'o4200, 12'o4600,
        12'o5000, 12'o5100, 12'o5300, 12'o5200, 12'o5600,
        12'o0400, 12'o0500, 12'o0700, 12'o0600, 12'o0101, 12'o0100,
        12'o0200, 12'o0300, 12'o7700
    };

    logic                clk;
    logic                reset;
    logic                in_valid;
    logic [`INSTR_W-1:0] in_instr;
    logic                in_credit;
    logic                out_valid;
    logic                out_credit;
    logic                out_reg_w, out_mem_r, out_mem_w, out_of_check, out_b_imm;
    logic                out_shamt_var, out_branch, out_jump, out_jr, out_rt_sel;
    logic [3:0]          out_alu_op;
    logic [1:0]          out_imm_ext, out_shift_op, out_res_sel, out_rd_sel;
    logic [4:0]          out_shamt;
    logic [2:0]          out_cond, out_load_sel, out_store_sel;

    logic [31:0] lfsr = 32'he3a6;
    logic [31:0] sent [$];   // Words in flight, oldest first
    int          errors = 0;
    int          received = 0;

    decode_stage_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #((10 + 40 * N_WORDS) * CLK_NS);
        $display("Watchdog expired after %0d of %0d words", received, N_WORDS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        repeat (n) v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic logic [31:0] make_word(logic [11:0] kind);
        logic [31:0] w;
        w = rand_bits(32);   // Register fields and immediate
        w[31:26] = kind[11:6];
        if (kind[11:6] inside {6'o00, 6'o34})
            w[5:0] = kind[5:0];
        else if (kind[11:6] == 6'o01)
            w[16] = kind[0];
        return w;
    endfunction

    function automatic ctrl_word_t expect_word(logic [31:0] w);
        ctrl_word_t e;
        logic [5:0] op;
        logic [5:0] fn;
        op = w[31:26];
        fn = w[5:0];
        e = '0;
        if (w == 32'h0)
            return e;
        case (op) inside
            6'o00: begin
                if (fn == 6'o10) begin
                    e.jr = 1'b1;
                    e.rd_sel = rd_rd;
                end else if (fn inside {6'o00, 6'o02, 6'o03, 6'o04, 6'o06, 6'o07}) begin
                    e.reg_w = 1'b1;
                    e.rd_sel = rd_rd;
                    e.res_sel = res_shift;
                    e.shamt = w[10:6];
                    e.shamt_var = (fn inside {6'o04, 6'o06, 6'o07});   // SLLV, SRLV, SRAV
                    e.shift_op = (fn[1:0] == 2'b00) ? sh_sll : (fn[0] ? sh_sra : sh_srl);
                end else if (fn inside {[6'o40:6'o47], 6'o52, 6'o53}) begin
                    e.reg_w = 1'b1;
                    e.rd_sel = rd_rd;
                    e.of_check = (fn == 6'o40 || fn == 6'o42);
                    case (fn)
                        6'o40:   e.alu_op = add_s;
                        6'o41:   e.alu_op = add_u;
                        6'o42:   e.alu_op = sub_s;
                        6'o43:   e.alu_op = sub_u;
                        6'o44:   e.alu_op = and_op;
                        6'o45:   e.alu_op = or_op;
                        6'o46:   e.alu_op = xor_op;
                        6'o47:   e.alu_op = nor_op;
                        6'o52:   e.alu_op = slt;
                        default: e.alu_op = sltu;
                    endcase
                end
            end
            6'o34: begin
                if (fn == 6'o40 || fn == 6'o41) begin
                    e.reg_w = 1'b1;
                    e.rd_sel = rd_rd;
                    e.alu_op = fn[0] ? clo : clz;
                end
            end
            [6'o04:6'o07], 6'o01: begin
                e.branch = 1'b1;
                e.alu_op = sub_u;
                e.imm_ext = ext_sign;
                e.rt_sel = !(op inside {6'o04, 6'o05});   // Compare with zero
                case (op)
                    6'o01:   e.cond = w[16] ? cond_gez : cond_lt;
                    6'o04:   e.cond = cond_eq;
                    6'o05:   e.cond = cond_ne;
                    6'o06:   e.cond = cond_le;
                    default: e.cond = cond_gt;
                endcase
            end
            6'o02: begin
                e.jump = 1'b1;
                e.imm_ext = ext_jump;
            end
            6'o03: begin
                e.jump = 1'b1;
                e.imm_ext = ext_jump;
                e.res_sel = res_link;
                e.rd_sel = rd_ra;
            end
            [6'o10:6'o17]: begin
                e.reg_w = 1'b1;
                e.b_imm = 1'b1;
                e.imm_ext = (op inside {6'o14, 6'o15, 6'o16}) ? ext_zero : ext_sign;
                case (op[2:0])
                    3'd0: begin
                        e.alu_op = add_s;
                        e.of_check = 1'b1;
                    end
                    3'd2:    e.alu_op = slt;
                    3'd3:    e.alu_op = sltu;
                    3'd4:    e.alu_op = and_op;
                    3'd5:    e.alu_op = or_op;
                    3'd6:    e.alu_op = xor_op;
                    3'd7:    e.imm_ext = ext_upper;   // LUI
                    default: ;
                endcase
            end
            [6'o40:6'o46]: begin
                e.reg_w = 1'b1;
                e.mem_r = 1'b1;
                e.b_imm = 1'b1;
                e.imm_ext = ext_sign;
                case (op[2:0])
                    3'd0:    e.load_sel = ld_lb;
                    3'd1:    e.load_sel = ld_lh;
                    3'd2:    e.load_sel = ld_lwl;
                    3'd3:    e.load_sel = ld_lw;
                    3'd4:    e.load_sel = ld_lbu;
                    3'd5:    e.load_sel = ld_lhu;
                    default: e.load_sel = ld_lwr;
                endcase
            end
            [6'o50:6'o53], 6'o56: begin
                e.mem_w = 1'b1;
                e.b_imm = 1'b1;
                e.imm_ext = ext_sign;
                case (op[2:0])
                    3'd0:    e.store_sel = st_sb;
                    3'd1:    e.store_sel = st_sh;
                    3'd2:    e.store_sel = st_swl;
                    3'd3:    e.store_sel = st_sw;
                    default: e.store_sel = st_swr;
                endcase
            end
            default: ;   // Unknown opcode decodes to nothing
        endcase
        return e;
    endfunction

    task automatic check_field(string name, logic [7:0] got, logic [7:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_word(ctrl_word_t e);
        check_field("out_reg_w", out_reg_w, e.reg_w);
        check_field("out_mem_r", out_mem_r, e.mem_r);
        check_field("out_mem_w", out_mem_w, e.mem_w);
        check_field("out_alu_op", out_alu_op, e.alu_op);
        check_field("out_of_check", out_of_check, e.of_check);
        check_field("out_b_imm", out_b_imm, e.b_imm);
        check_field("out_imm_ext", out_imm_ext, e.imm_ext);
        check_field("out_shift_op", out_shift_op, e.shift_op);
        check_field("out_shamt_var", out_shamt_var, e.shamt_var);
        check_field("out_shamt", out_shamt, e.shamt);
        check_field("out_res_sel", out_res_sel, e.res_sel);
        check_field("out_branch", out_branch, e.branch);
        check_field("out_cond", out_cond, e.cond);
        check_field("out_jump", out_jump, e.jump);
        check_field("out_jr", out_jr, e.jr);
        check_field("out_rd_sel", out_rd_sel, e.rd_sel);
        check_field("out_rt_sel", out_rt_sel, e.rt_sel);
        check_field("out_load_sel", out_load_sel, e.load_sel);
        check_field("out_store_sel", out_store_sel, e.store_sel);
    endtask

    // Consumer side, checks each word and returns credits after a random gap
    initial begin : consumer
        int owed;
        int gap;
        owed = 0;
        gap = 0;
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (out_valid) begin
                if (sent.size() == 0) begin
                    $display("Control word presented at %0t ns with no word outstanding", $time);
                    errors++;
                end else begin
                    compare_word(expect_word(sent.pop_front()));
                    received++;
                end
                owed++;
            end
            out_credit = 1'b0;
            if (owed > 0) begin
                if (gap == 0) begin
                    out_credit = 1'b1;
                    owed--;
                    gap = rand_bits(2);
                end else begin
                    gap--;
                end
            end
        end
    end

    initial begin : sender
        logic [31:0] words [$];
        int          k;
        int          credits;
        k = 0;
        credits = `FIFO_DEPTH;
        reset = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        for (int n = 0; n < N_KINDS; n++)
            words.push_back(make_word(KINDS[n]));
        words.push_back(32'h0);   // NOP
        repeat (N_RANDOM) words.push_back(make_word(KINDS[rand_bits(6) % N_KINDS]));

        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (5) begin
            @(posedge clk);
            #2;
        end

        while (received < N_WORDS) begin
            in_valid = 1'b0;
            if (k < N_WORDS && credits > 0) begin
                in_valid = 1'b1;
                in_instr = words[k];
                sent.push_back(words[k]);
                credits--;
                k++;
            end
            if (in_credit)
                credits++;   // Usable from the next cycle
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
        repeat (10) @(posedge clk);   // Room for any stray extra word

        $display("Errors: %0d in field checks, %0d in protocol assertions",
                 errors, dut.chk.fails);
        if (errors == 0 && dut.chk.fails == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/decode_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_defs.svh"

module decode_chk (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic in_credit,
    input logic pop,
    input logic head_valid,
    input logic out_valid,
    input logic out_credit
);

    int unsigned fails = 0;
    int          words_in;   // Accepted since reset
    int          stored;     // Words in the buffer
    int          held;       // Presented and not yet credited back

    always_ff @(posedge clk) begin
        if (reset) begin
            words_in <= 0;
            stored   <= 0;
            held     <= 0;
        end else begin
            words_in <= words_in + int'(in_valid);
            stored   <= stored + int'(in_valid) - int'(in_credit);
            held     <= held + int'(out_valid) - int'(out_credit);
        end
    end

    quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        words_in == 0 |-> !out_valid && !in_credit)
        else begin $error("Output or credit activity before any word was sent"); fails++; end

    pop_needs_head: assert property (@(posedge clk) disable iff (reset) pop |-> stored > 0)
        else begin $error("Buffer popped while empty"); fails++; end

    credit_after_accept: assert property (@(posedge clk) disable iff (reset)
        in_credit |-> stored > 0)
        else begin $error("Upstream credit returned with no word held"); fails++; end

    no_overflow: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> stored < `FIFO_DEPTH)
        else begin $error("Word accepted into a full buffer"); fails++; end

    out_within_credits: assert property (@(posedge clk) disable iff (reset)
        held + int'(out_valid) <= `OUT_CREDITS)
        else begin $error("More words presented than downstream credits allow"); fails++; end

    // Consumer full, next cycle stays quiet
    stall_stops_output: assert property (@(posedge clk) disable iff (reset)
        held == `OUT_CREDITS |=> !out_valid)
        else begin $error("Output moved while the consumer was stalled"); fails++; end

    resume_output: assert property (@(posedge clk) disable iff (reset)
        held == 0 && head_valid |=> out_valid)
        else begin $error("Output did not resume with credits and a waiting word"); fails++; end

endmodule

bind decode_stage_top decode_chk chk (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .pop        (pop),
    .head_valid (head_valid),
    .out_valid  (out_valid),
    .out_credit (out_credit)
);

`default_nettype wire

// File: verilog/decode_stage_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_defs.svh"

module decode_stage_top import isa_pkg::*, ctrl_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  logic [`INSTR_W-1:0]           in_instr,
    output logic                          in_credit,
    output logic                          out_valid,
    input  logic                          out_credit,
    output logic                          out_reg_w,
    output logic                          out_mem_r,
    output logic                          out_mem_w,
    output logic [$bits(alu_op_e)-1:0]    out_alu_op,
    output logic                          out_of_check,
    output logic                          out_b_imm,
    output logic [$bits(imm_ext_e)-1:0]   out_imm_ext,
    output logic [$bits(shift_op_e)-1:0]  out_shift_op,
    output logic                          out_shamt_var,
    output logic [4:0]                    out_shamt,
    output logic [$bits(res_sel_e)-1:0]   out_res_sel,
    output logic                          out_branch,
    output logic [$bits(cond_e)-1:0]      out_cond,
    output logic                          out_jump,
    output logic                          out_jr,
    output logic [$bits(rd_sel_e)-1:0]    out_rd_sel,
    output logic                          out_rt_sel,
    output logic [$bits(load_sel_e)-1:0]  out_load_sel,
    output logic [$bits(store_sel_e)-1:0] out_store_sel
);

    ctrl_if     ctl ();
    instr_t     head_instr;
    ctrl_word_t out_word;
    logic       head_valid;
    logic       pop;

    instr_fifo u_fifo (
        .clk, .reset, .in_valid, .in_instr, .pop,
        .head_valid, .head_instr, .in_credit
    );

    alu_decoder  u_alu_dec  (.instr(head_instr), .ctl(ctl.alu));
    mem_decoder  u_mem_dec  (.instr(head_instr), .ctl(ctl.mem));
    flow_decoder u_flow_dec (.instr(head_instr), .ctl(ctl.flow));

    decode_pipe u_pipe (
        .clk, .reset, .head_valid, .pop, .ctl(ctl.pipe),
        .out_credit, .out_valid, .out_word
    );

    assign {out_reg_w, out_mem_r, out_mem_w, out_alu_op, out_of_check, out_b_imm,
            out_imm_ext, out_shift_op, out_shamt_var, out_shamt, out_res_sel,
            out_branch, out_cond, out_jump, out_jr, out_rd_sel, out_rt_sel,
            out_load_sel, out_store_sel} = out_word;

endmodule

`default_nettype wire

// File: verilog/decode_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_defs.svh"

module decode_pipe import ctrl_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       head_valid,
    output logic       pop,
    ctrl_if.pipe       ctl,
    input  logic       out_credit,
    output logic       out_valid,
    output ctrl_word_t out_word
);

    logic [`CREDIT_W-1:0] credits;   // Free slots at the consumer

    assign pop = head_valid && (credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            credits   <= `CREDIT_W'(`OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
            case ({pop, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;   // Both or neither
            endcase
        end
    end

    // Field order follows ctrl_word_t
    always_ff @(posedge clk) begin
        if (pop)
            out_word <= {ctl.reg_w, ctl.mem_r, ctl.mem_w, ctl.alu_op, ctl.of_check,
                         ctl.b_imm, ctl.imm_ext, ctl.shift_op, ctl.shamt_var, ctl.shamt,
                         ctl.res_sel, ctl.branch, ctl.cond, ctl.jump, ctl.jr,
                         ctl.rd_sel, ctl.rt_sel, ctl.load_sel, ctl.store_sel};
    end

endmodule

`default_nettype wire

// File: verilog/flow_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module flow_decoder import isa_pkg::*, ctrl_pkg::*; (
    input  instr_t instr,
    ctrl_if.flow   ctl
);

    always_comb begin
        ctl.branch = 1'b0;
        ctl.cond   = cond_none;
        ctl.jump   = 1'b0;
        ctl.jr     = 1'b0;
        ctl.rd_sel = rd_rt;
        ctl.rt_sel = 1'b0;
        case (instr.i.opcode)
            op_special: begin
                case (instr.r.funct)
                    fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor,
                    fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav:
                        ctl.rd_sel = (instr != '0) ? rd_rd : rd_rt;
                    fn_jr: begin
                        ctl.jr     = 1'b1;
                        ctl.rd_sel = rd_rd;
                    end
                    default: ;
                endcase
            end
            op_special2: begin
                if (instr.r.funct[5:1] == 5'b10000)
                    ctl.rd_sel = rd_rd;
            end
            op_regimm: begin
                ctl.branch = 1'b1;
                ctl.rt_sel = 1'b1;
                ctl.cond   = instr.i.rt[0] ? cond_gez : cond_lt;   // Bit 16
            end
            op_beq: begin
                ctl.branch = 1'b1;
                ctl.cond   = cond_eq;
            end
            op_bne: begin
                ctl.branch = 1'b1;
                ctl.cond   = cond_ne;
            end
            op_bgtz: begin
                ctl.branch = 1'b1;
                ctl.cond   = cond_gt;
                ctl.rt_sel = 1'b1;
            end
            op_blez: begin
                ctl.branch = 1'b1;
                ctl.cond   = cond_le;
                ctl.rt_sel = 1'b1;
            end
            op_j:   ctl.jump = 1'b1;
            op_jal: begin
                ctl.jump   = 1'b1;
                ctl.rd_sel = rd_ra;   // Link into r31
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/mem_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module mem_decoder import isa_pkg::*, ctrl_pkg::*; (
    input  instr_t instr,
    ctrl_if.mem    ctl
);

    always_comb begin
        ctl.reg_w     = 1'b0;
        ctl.mem_r     = 1'b0;
        ctl.mem_w     = 1'b0;
        ctl.load_sel  = ld_lb;
        ctl.store_sel = st_sb;
        case (instr.i.opcode)
            op_special: begin
                case (instr.r.funct)
                    fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor,
                    fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav:
                        ctl.reg_w = (instr != '0);   // NOP writes nothing
                    default: ;
                endcase
            end
            op_special2: ctl.reg_w = (instr.r.funct[5:1] == 5'b10000);
            op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui:
                ctl.reg_w = 1'b1;
            op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr: begin
                ctl.mem_r = 1'b1;
                ctl.reg_w = 1'b1;
            end
            op_sb, op_sh, op_sw, op_swl, op_swr: ctl.mem_w = 1'b1;
            default: ;
        endcase

        // Width and alignment selects, LB and SB are the zero codes
        case (instr.i.opcode)
            op_lbu:  ctl.load_sel = ld_lbu;
            op_lh:   ctl.load_sel = ld_lh;
            op_lhu:  ctl.load_sel = ld_lhu;
            op_lw:   ctl.load_sel = ld_lw;
            op_lwl:  ctl.load_sel = ld_lwl;
            op_lwr:  ctl.load_sel = ld_lwr;
            op_sh:   ctl.store_sel = st_sh;
            op_sw:   ctl.store_sel = st_sw;
            op_swl:  ctl.store_sel = st_swl;
            op_swr:  ctl.store_sel = st_swr;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/alu_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module alu_decoder import isa_pkg::*, ctrl_pkg::*; (
    input  instr_t instr,
    ctrl_if.alu    ctl
);

    always_comb begin
        ctl.alu_op    = add_u;
        ctl.of_check  = 1'b0;
        ctl.b_imm     = 1'b0;
        ctl.imm_ext   = ext_zero;
        ctl.shift_op  = sh_sll;
        ctl.shamt_var = 1'b0;
        ctl.shamt     = '0;
        ctl.res_sel   = res_alu;
        case (instr.r.opcode)
            op_special: begin
                case (instr.r.funct)
                    fn_add: begin
                        ctl.alu_op   = add_s;
                        ctl.of_check = 1'b1;
                    end
                    fn_sub: begin
                        ctl.alu_op   = sub_s;
                        ctl.of_check = 1'b1;
                    end
                    fn_addu: ctl.alu_op = add_u;
                    fn_subu: ctl.alu_op = sub_u;
                    fn_and:  ctl.alu_op = and_op;
                    fn_or:   ctl.alu_op = or_op;
                    fn_xor:  ctl.alu_op = xor_op;
                    fn_nor:  ctl.alu_op = nor_op;
                    fn_slt:  ctl.alu_op = slt;
                    fn_sltu: ctl.alu_op = sltu;
                    fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav: begin
                        if (instr != '0) begin   // All-zero word is the NOP
                            ctl.res_sel   = res_shift;
                            ctl.shamt_var = instr.r.funct[2];
                            ctl.shamt     = instr.r.shamt;
                            case (instr.r.funct[1:0])
                                2'b10:   ctl.shift_op = sh_srl;
                                2'b11:   ctl.shift_op = sh_sra;
                                default: ctl.shift_op = sh_sll;
                            endcase
                        end
                    end
                    default: ;
                endcase
            end
            op_special2: begin
                if (instr.r.funct[5:1] == 5'b10000)
                    ctl.alu_op = instr.r.funct[0] ? clo : clz;
            end
            op_regimm, op_beq, op_bne, op_blez, op_bgtz: begin
                ctl.alu_op  = sub_u;   // Branch compare by subtraction
                ctl.imm_ext = ext_sign;
            end
            op_j: ctl.imm_ext = ext_jump;
            op_jal: begin
                ctl.imm_ext = ext_jump;
                ctl.res_sel = res_link;
            end
            op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
                ctl.b_imm   = 1'b1;
                ctl.imm_ext = ext_sign;
                case (instr.i.opcode)
                    op_addi: begin
                        ctl.alu_op   = add_s;
                        ctl.of_check = 1'b1;
                    end
                    op_slti:  ctl.alu_op = slt;
                    op_sltiu: ctl.alu_op = sltu;
                    op_andi:  ctl.alu_op = and_op;
                    op_ori:   ctl.alu_op = or_op;
                    op_xori:  ctl.alu_op = xor_op;
                    op_lui:   ctl.imm_ext = ext_upper;
                    default:  ;
                endcase
                // Logic immediates are zero extended
                if (instr.i.opcode inside {op_andi, op_ori, op_xori})
                    ctl.imm_ext = ext_zero;
            end
            op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr,
            op_sb, op_sh, op_sw, op_swl, op_swr: begin
                ctl.b_imm   = 1'b1;   // Base plus offset
                ctl.imm_ext = ext_sign;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/instr_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_defs.svh"

module instr_fifo import isa_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  logic [`INSTR_W-1:0] in_instr,
    input  logic                pop,
    output logic                head_valid,
    output instr_t              head_instr,
    output logic                in_credit
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    instr_t               mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [`CREDIT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid)
                wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid)
            mem[wr_ptr] <= instr_t'(in_instr);
    end

    assign head_valid = (count != '0);
    assign head_instr = mem[rd_ptr];   // Read-through head
    assign in_credit  = pop;           // Freed entry goes straight back to the sender

endmodule

`default_nettype wire

// File: verilog/ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

// Control fields from the three decoders to the output register
interface ctrl_if;
    logic       reg_w;
    logic       mem_r;
    logic       mem_w;
    logic [3:0] alu_op;
    logic       of_check;
    logic       b_imm;
    logic [1:0] imm_ext;
    logic [1:0] shift_op;
    logic       shamt_var;
    logic [4:0] shamt;
    logic [1:0] res_sel;
    logic       branch;
    logic [2:0] cond;
    logic       jump;
    logic       jr;
    logic [1:0] rd_sel;
    logic       rt_sel;
    logic [2:0] load_sel;
    logic [2:0] store_sel;

    modport alu  (output alu_op, of_check, b_imm, imm_ext, shift_op, shamt_var, shamt, res_sel);
    modport mem  (output reg_w, mem_r, mem_w, load_sel, store_sel);
    modport flow (output branch, cond, jump, jr, rd_sel, rt_sel);
    modport pipe (input reg_w, mem_r, mem_w, alu_op, of_check, b_imm, imm_ext, shift_op,
                  shamt_var, shamt, res_sel, branch, cond, jump, jr, rd_sel, rt_sel,
                  load_sel, store_sel);
endinterface

`default_nettype wire

// File: verilog/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [3:0] {
        add_u  = 4'b0000,
        sub_u  = 4'b0001,
        clz    = 4'b0010,
        clo    = 4'b0011,
        and_op = 4'b0100,
        slt    = 4'b0101,
        or_op  = 4'b0110,
        sltu   = 4'b0111,
        nor_op = 4'b1000,
        xor_op = 4'b1001,
        add_s  = 4'b1110,   // Overflow traps
        sub_s  = 4'b1111
    } alu_op_e;

    typedef enum logic [1:0] {sh_sll, sh_srl, sh_sra} shift_op_e;

    typedef enum logic [2:0] {
        cond_none, cond_eq, cond_ne, cond_gez, cond_gt, cond_le, cond_lt
    } cond_e;

    typedef enum logic [2:0] {
        ld_lb, ld_lbu, ld_lh, ld_lhu, ld_lw, ld_lwl, ld_lwr
    } load_sel_e;

    typedef enum logic [2:0] {st_sb, st_sh, st_sw, st_swl, st_swr} store_sel_e;

    typedef enum logic [1:0] {ext_zero, ext_sign, ext_upper, ext_jump} imm_ext_e;

    typedef enum logic [1:0] {res_alu, res_shift, res_link} res_sel_e;

    typedef enum logic [1:0] {rd_rt, rd_rd, rd_ra} rd_sel_e;

    typedef struct packed {
        logic       reg_w;
        logic       mem_r;
        logic       mem_w;
        alu_op_e    alu_op;
        logic       of_check;
        logic       b_imm;      // Operand B from the immediate
        imm_ext_e   imm_ext;
        shift_op_e  shift_op;
        logic       shamt_var;  // Shift amount from rs
        logic [4:0] shamt;
        res_sel_e   res_sel;
        logic       branch;
        cond_e      cond;
        logic       jump;
        logic       jr;
        rd_sel_e    rd_sel;
        logic       rt_sel;     // Compare against zero, not rt
        load_sel_e  load_sel;
        store_sel_e store_sel;
    } ctrl_word_t;

endpackage

`default_nettype wire

// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;   // Low 16 of the jump target for J/JAL
    } i_view_t;

    // Same 32 bits, read as R-type or as I/J-type
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_t;

    // Octal, as in the MIPS opcode table
    typedef enum logic [5:0] {
        op_special = 6'o00, op_regimm = 6'o01, op_j     = 6'o02, op_jal   = 6'o03,
        op_beq     = 6'o04, op_bne    = 6'o05, op_blez  = 6'o06, op_bgtz  = 6'o07,
        op_addi    = 6'o10, op_addiu  = 6'o11, op_slti  = 6'o12, op_sltiu = 6'o13,
        op_andi    = 6'o14, op_ori    = 6'o15, op_xori  = 6'o16, op_lui   = 6'o17,
        op_special2 = 6'o34,
        op_lb      = 6'o40, op_lh     = 6'o41, op_lwl   = 6'o42, op_lw    = 6'o43,
        op_lbu     = 6'o44, op_lhu    = 6'o45, op_lwr   = 6'o46,
        op_sb      = 6'o50, op_sh     = 6'o51, op_swl   = 6'o52, op_sw    = 6'o53,
        op_swr     = 6'o56
    } opcode_e;

    // SPECIAL function codes; CLO/CLZ under SPECIAL2 are decoded by bit 0
    typedef enum logic [5:0] {
        fn_sll  = 6'o00, fn_srl  = 6'o02, fn_sra  = 6'o03,
        fn_sllv = 6'o04, fn_srlv = 6'o06, fn_srav = 6'o07,
        fn_jr   = 6'o10,
        fn_add  = 6'o40, fn_addu = 6'o41, fn_sub  = 6'o42, fn_subu = 6'o43,
        fn_and  = 6'o44, fn_or   = 6'o45, fn_xor  = 6'o46, fn_nor  = 6'o47,
        fn_slt  = 6'o52, fn_sltu = 6'o53
    } funct_e;

endpackage

`default_nettype wire

// File: verilog/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define INSTR_W     32

// Buffer entries, also the credits the sender starts with
`define FIFO_DEPTH  4

`define OUT_CREDITS 2

// Holds 0 up to FIFO_DEPTH
`define CREDIT_W    3

`endif
